// File: include/capi_job_params.svh
`ifndef CAPI_JOB_PARAMS_SVH
`define CAPI_JOB_PARAMS_SVH

////////////////////
// Job control sizing
////////////////////

// Cycles the accelerator reset stays low after a RESET command
`define JOB_RESET_CYCLES 8

// Width of the reset hold down counter
// Must be wide enough to hold JOB_RESET_CYCLES
`define JOB_TIMER_WIDTH 8

`endif

// File: logic/capi_job_pkg.sv
package capi_job_pkg;

  ////////////////////
  // Job commands
  ////////////////////

  // Host link job command codes
  // Only RESET and START are acted on, any other code is ignored
  typedef enum logic [7:0] {
    RESET = 8'h80,
    START = 8'h90
  } job_command_e;

  ////////////////////
  // Error reporting
  ////////////////////

  // Error word returned to the host together with job done
  // Zero means the job finished cleanly
  typedef logic [63:0] job_error_t;

  // Parity check result for one command
  // A set bit means the field failed its odd parity check
  typedef struct packed {
    logic command_err;
    logic address_err;
  } parity_err_t;

endpackage

// File: logic/job_cmd_if.sv
`timescale 1ns/1ns

// Registered job command as seen inside the design
interface job_cmd_if;

  // One cycle strobe per command, no back-pressure
  logic                       valid;
  capi_job_pkg::job_command_e command;
  logic [63:0]                address;

  // Odd parity bits as received from the host
  logic                       command_parity;
  logic                       address_parity;

  // Sequencer owns the input register
  modport sequencer (
    output valid, command, address, command_parity, address_parity
  );

  // Parity checker only looks at the command
  modport check (
    input valid, command, address, command_parity, address_parity
  );

endinterface

// File: logic/reset_timer.sv
`timescale 1ns/1ns
`include "capi_job_params.svh"

module reset_timer (
  input  logic clock,
  input  logic rstn,
  input  logic load,
  output logic expired
);

  localparam int unsigned W = `JOB_TIMER_WIDTH;

  // The load cycle is the first hold cycle, so count from one less
  localparam logic [W-1:0] LOAD_VALUE = W'(`JOB_RESET_CYCLES - 1);

  logic [W-1:0] count;

  ////////////////////
  // Down counter
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      count   <= '0;
      expired <= 1'b0;
    end else if (load) begin
      // Reload restarts a running count
      count   <= LOAD_VALUE;
      // A one cycle hold expires straight away
      expired <= (`JOB_RESET_CYCLES == 1);
    end else begin
      // Pulse on the edge the count lands on zero
      expired <= (count == W'(1));
      if (count != '0) begin
        count <= count - W'(1);
      end
    end
  end

endmodule

// File: logic/parity_checker.sv
`timescale 1ns/1ns

module parity_checker (
  input  logic                      clock,
  input  logic                      rstn,
  job_cmd_if.check                  cmd,
  input  logic                      done_pulse,
  output capi_job_pkg::parity_err_t parity_errors
);

  logic [7:0]                held_command;
  logic [63:0]               held_address;
  logic                      held_command_parity;
  logic                      held_address_parity;
  capi_job_pkg::parity_err_t raw_err;
  capi_job_pkg::parity_err_t stage_err;

  ////////////////////
  // Command hold
  ////////////////////

  // Cleared value is all zero with parity one, which checks clean
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      held_command        <= '0;
      held_address        <= '0;
      held_command_parity <= 1'b1;
      held_address_parity <= 1'b1;
    end else if (cmd.valid) begin
      // New command takes priority over the clear
      held_command        <= cmd.command;
      held_address        <= cmd.address;
      held_command_parity <= cmd.command_parity;
      held_address_parity <= cmd.address_parity;
    end else if (done_pulse) begin
      held_command        <= '0;
      held_address        <= '0;
      held_command_parity <= 1'b1;
      held_address_parity <= 1'b1;
    end
  end

  // Odd parity over field plus its bit must come out as one
  assign raw_err.command_err = ~(^{held_command, held_command_parity});
  assign raw_err.address_err = ~(^{held_address, held_address_parity});

  ////////////////////
  // Error pipeline
  ////////////////////

  // Two stages, flags show three edges after the input sample
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      stage_err     <= '0;
      parity_errors <= '0;
    end else begin
      stage_err     <= raw_err;
      parity_errors <= stage_err;
    end
  end

endmodule

// File: logic/error_capture.sv
`timescale 1ns/1ns

module error_capture (
  input  logic                     clock,
  input  logic                     rstn,
  input  capi_job_pkg::job_error_t report_errors,
  input  logic                     job_reset_cmd,
  input  logic                     done_pulse,
  output capi_job_pkg::job_error_t job_error
);

  capi_job_pkg::job_error_t held_error;

  ////////////////////
  // First error latch
  ////////////////////

  // Sample every cycle until something nonzero shows up
  // After that the word sticks until the next RESET
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      held_error <= '0;
    end else if (job_reset_cmd) begin
      held_error <= '0;
    end else if (held_error == '0) begin
      held_error <= report_errors;
    end
  end

  ////////////////////
  // Report to host
  ////////////////////

  // Only valid alongside job done, zero otherwise
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      job_error <= '0;
    end else if (done_pulse) begin
      job_error <= held_error;
    end else begin
      job_error <= '0;
    end
  end

endmodule

// File: logic/job_sequencer.sv
`timescale 1ns/1ns
`include "capi_job_params.svh"

module job_sequencer (
  input  logic                clock,
  input  logic                rstn,
  input  logic                job_valid,
  input  logic [7:0]          job_command,
  input  logic [63:0]         job_address,
  input  logic                job_command_parity,
  input  logic                job_address_parity,
  input  logic                timer_expired,
  job_cmd_if.sequencer        cmd,
  output logic                timer_load,
  output logic                job_reset_cmd,
  output logic                done_pulse,
  output logic                afu_reset_n,
  output logic                job_running,
  output logic                job_done
);

  typedef enum logic [1:0] {
    IDLE,
    RESET_HOLD,
    DONE,
    RUNNING
  } state_e;

  state_e state;
  state_e state_next;
  logic   reset_seen;
  logic   start_seen;

  // Hold length has to fit the timer
  if (`JOB_RESET_CYCLES < 1 || `JOB_RESET_CYCLES >= (1 << `JOB_TIMER_WIDTH)) begin : g_bad_cfg
    $error("JOB_RESET_CYCLES does not fit in JOB_TIMER_WIDTH bits");
  end

  ////////////////////
  // Input register
  ////////////////////

  // Strobe is control state
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= job_valid;
    end
  end

  // Payload only matters while valid is high
  always_ff @(posedge clock) begin
    cmd.command        <= capi_job_pkg::job_command_e'(job_command);
    cmd.address        <= job_address;
    cmd.command_parity <= job_command_parity;
    cmd.address_parity <= job_address_parity;
  end

  // Decode of the registered command
  assign reset_seen = cmd.valid && (cmd.command == capi_job_pkg::RESET);
  assign start_seen = cmd.valid && (cmd.command == capi_job_pkg::START);

  // Timer start and error word clear, same cycle as the decode
  assign timer_load    = reset_seen;
  assign job_reset_cmd = reset_seen;

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_next = state;
    // RESET wins from any state and restarts the hold
    if (reset_seen) begin
      state_next = RESET_HOLD;
    end else begin
      case (state)
        IDLE:       if (start_seen) state_next = RUNNING;
        RESET_HOLD: if (timer_expired) state_next = DONE;
        // Done lasts one cycle, a START here is still honoured
        DONE:       state_next = start_seen ? RUNNING : IDLE;
        RUNNING:    state_next = RUNNING;
        default:    state_next = IDLE;
      endcase
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state       <= IDLE;
      afu_reset_n <= 1'b1;
      job_running <= 1'b0;
      job_done    <= 1'b0;
    end else begin
      state       <= state_next;
      // Outputs follow the next state so they move on the decode edge
      afu_reset_n <= (state_next != RESET_HOLD);
      job_running <= (state_next == RUNNING);
      // One cycle behind done_pulse, lines up with job_error
      job_done    <= done_pulse;
    end
  end

  // afu_reset_n is already high while in DONE
  assign done_pulse = (state == DONE);

endmodule

// File: logic/job_control.sv
`timescale 1ns/1ns

module job_control (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic                      job_valid,
  input  logic [7:0]                job_command,
  input  logic [63:0]               job_address,
  input  logic                      job_command_parity,
  input  logic                      job_address_parity,
  input  capi_job_pkg::job_error_t  report_errors,
  output logic                      afu_reset_n,
  output logic                      job_running,
  output logic                      job_done,
  output capi_job_pkg::job_error_t  job_error,
  output capi_job_pkg::parity_err_t parity_errors
);

  // Sequencer to timer handshake
  logic timer_load;
  logic timer_expired;

  // Sequencer strobes to the error side
  logic job_reset_cmd;
  logic done_pulse;

  // Registered command bus
  job_cmd_if cmd_bus ();

  ////////////////////
  // Control path
  ////////////////////

  job_sequencer u_sequencer (
    .clock              (clock),
    .rstn               (rstn),
    .job_valid          (job_valid),
    .job_command        (job_command),
    .job_address        (job_address),
    .job_command_parity (job_command_parity),
    .job_address_parity (job_address_parity),
    .timer_expired      (timer_expired),
    .cmd                (cmd_bus.sequencer),
    .timer_load         (timer_load),
    .job_reset_cmd      (job_reset_cmd),
    .done_pulse         (done_pulse),
    .afu_reset_n        (afu_reset_n),
    .job_running        (job_running),
    .job_done           (job_done)
  );

  reset_timer u_timer (
    .clock   (clock),
    .rstn    (rstn),
    .load    (timer_load),
    .expired (timer_expired)
  );

  ////////////////////
  // Error path
  ////////////////////

  parity_checker u_parity (
    .clock         (clock),
    .rstn          (rstn),
    .cmd           (cmd_bus.check),
    .done_pulse    (done_pulse),
    .parity_errors (parity_errors)
  );

  error_capture u_errors (
    .clock         (clock),
    .rstn          (rstn),
    .report_errors (report_errors),
    .job_reset_cmd (job_reset_cmd),
    .done_pulse    (done_pulse),
    .job_error     (job_error)
  );

endmodule

// File: tb/job_control_properties.sv
`timescale 1ns/1ns

module job_control_properties (
  input logic                     clock,
  input logic                     rstn,
  input logic                     job_done,
  input logic                     afu_reset_n,
  input capi_job_pkg::job_error_t job_error
);

  // Running total of assertion failures, read by the testbench at the end
  int failure_count = 0;

  ////////////////////
  // Done handshake
  ////////////////////

  // Done is a single cycle pulse
  a_done_single : assert property (@(posedge clock) disable iff (!rstn)
    job_done |=> !job_done)
  else begin
    $error("job_done stayed high for two cycles");
    failure_count++;
  end

  // Error word only carries data next to done
  a_error_quiet : assert property (@(posedge clock) disable iff (!rstn)
    !job_done |-> (job_error == '0))
  else begin
    $error("job_error is nonzero while job_done is low");
    failure_count++;
  end

  // Accelerator is out of reset when done is reported
  a_reset_released : assert property (@(posedge clock) disable iff (!rstn)
    job_done |-> afu_reset_n)
  else begin
    $error("afu_reset_n is low while job_done is high");
    failure_count++;
  end

endmodule

bind job_control job_control_properties u_properties (
  .clock       (clock),
  .rstn        (rstn),
  .job_done    (job_done),
  .afu_reset_n (afu_reset_n),
  .job_error   (job_error)
);

// File: tb/job_control_tb.sv
`timescale 1ns/1ns
`include "capi_job_params.svh"

module job_control_tb;

  localparam int NUM_STEPS    = 9;
  // Sampling edge to job_done rising edge
  localparam int DONE_LATENCY = `JOB_RESET_CYCLES + 2;
  localparam int DONE_TIMEOUT = DONE_LATENCY + 20;

  // One row per host command
  typedef struct packed {
    logic [7:0]                code;
    logic                      bad_cmd;
    logic                      bad_addr;
    logic                      report_en;
    capi_job_pkg::parity_err_t exp_parity;
    logic                      exp_running;
  } step_t;

  logic                      clock;
  logic                      rstn;
  logic                      job_valid;
  logic [7:0]                job_command;
  logic [63:0]               job_address;
  logic                      job_command_parity;
  logic                      job_address_parity;
  capi_job_pkg::job_error_t  report_errors;
  logic                      afu_reset_n;
  logic                      job_running;
  logic                      job_done;
  capi_job_pkg::job_error_t  job_error;
  capi_job_pkg::parity_err_t parity_errors;

  step_t                    steps [NUM_STEPS];
  int                       checks;
  int                       value_errors;
  int                       timeouts;
  int                       edge_count;
  int                       start_edge;
  int                       i;
  capi_job_pkg::job_error_t expected_error;

  job_control UUT (.*);

  always #2 clock = ~clock;

  ////////////////////
  // Helpers
  ////////////////////

  // Every step lands on a falling edge where outputs are stable
  task automatic next_edge();
    @(negedge clock);
    edge_count++;
  endtask

  function automatic logic [63:0] random_word();
    return {$urandom, $urandom};
  endfunction

  task automatic check_parity(input string name, input capi_job_pkg::parity_err_t exp,
                              input capi_job_pkg::parity_err_t act);
    checks++;
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_error(input string name, input capi_job_pkg::job_error_t exp,
                             input capi_job_pkg::job_error_t act);
    checks++;
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    checks++;
    if (act != exp) begin
      $display("[ERROR] %0t ns job_done latency expected %0d got %0d", $time, exp, act);
      value_errors++;
    end
  endtask

  // Wait out the reset hold and check the done cycle and the cleanup after it
  task automatic finish_job();
    while (!job_done && (edge_count - start_edge) < DONE_TIMEOUT) begin
      next_edge();
    end
    if (!job_done) begin
      $display("Timed out at %0t ns waiting for job_done after a RESET command", $time);
      timeouts++;
    end else begin
      check_latency(DONE_LATENCY, edge_count - start_edge);
      check_error("job_error", expected_error, job_error);
      check_flag("afu_reset_n", 1'b1, afu_reset_n);
      next_edge();
      check_flag("job_done", 1'b0, job_done);
      check_error("job_error", '0, job_error);
      // Done clears the held command and the flags drain two edges later
      next_edge();
      check_parity("parity_errors", '0, parity_errors);
      check_flag("job_running", 1'b0, job_running);
    end
  endtask

  task automatic run_step(input step_t s);
    logic is_reset;
    is_reset           = (s.code == capi_job_pkg::RESET);
    // Odd parity bits flipped where the row asks for a bad bit
    job_valid          = 1'b1;
    job_command        = s.code;
    job_address        = random_word();
    job_command_parity = ~(^s.code) ^ s.bad_cmd;
    job_address_parity = ~(^job_address) ^ s.bad_addr;
    next_edge();
    start_edge = edge_count;
    job_valid  = 1'b0;
    next_edge();
    check_flag("job_running", s.exp_running, job_running);
    if (is_reset) begin
      check_flag("afu_reset_n", 1'b0, afu_reset_n);
      // First word after the clear is the one to keep
      expected_error = s.report_en ? (random_word() | 64'd1) : '0;
      report_errors  = expected_error;
    end
    next_edge();
    if (is_reset && s.report_en) begin
      report_errors = random_word() | 64'd1;
    end
    next_edge();
    check_parity("parity_errors", s.exp_parity, parity_errors);
    report_errors = '0;
    if (is_reset) begin
      finish_job();
    end
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////

  // code, bad command parity, bad address parity, report, parity flags, running
  initial begin
    steps[0] = {capi_job_pkg::START, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1};
    steps[1] = {8'h00,               1'b1, 1'b0, 1'b0, 2'b10, 1'b1};
    steps[2] = {8'h3C,               1'b0, 1'b1, 1'b0, 2'b01, 1'b1};
    steps[3] = {capi_job_pkg::START, 1'b1, 1'b1, 1'b0, 2'b11, 1'b1};
    steps[4] = {capi_job_pkg::RESET, 1'b0, 1'b0, 1'b1, 2'b00, 1'b0};
    steps[5] = {8'hA5,               1'b0, 1'b0, 1'b0, 2'b00, 1'b0};
    steps[6] = {capi_job_pkg::START, 1'b1, 1'b1, 1'b0, 2'b11, 1'b1};
    steps[7] = {capi_job_pkg::RESET, 1'b1, 1'b0, 1'b0, 2'b10, 1'b0};
    steps[8] = {capi_job_pkg::START, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1};
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(52));
    clock              = 1'b0;
    rstn               = 1'b0;
    job_valid          = 1'b0;
    job_command        = '0;
    job_address        = '0;
    job_command_parity = 1'b0;
    job_address_parity = 1'b0;
    report_errors      = '0;
    checks             = 0;
    value_errors       = 0;
    timeouts           = 0;
    edge_count         = 0;
    expected_error     = '0;
    repeat (3) @(negedge clock);
    rstn = 1'b1;
    next_edge();
    // Idle state straight out of reset
    check_flag("afu_reset_n", 1'b1, afu_reset_n);
    check_flag("job_running", 1'b0, job_running);
    check_flag("job_done", 1'b0, job_done);
    check_error("job_error", '0, job_error);
    check_parity("parity_errors", '0, parity_errors);
    for (i = 0; i < NUM_STEPS; i++) begin
      run_step(steps[i]);
    end
    next_edge();
    $display("Checks: %0d  value errors: %0d  timeouts: %0d  assertion failures: %0d",
             checks, value_errors, timeouts, UUT.u_properties.failure_count);
    if (value_errors == 0 && timeouts == 0 && UUT.u_properties.failure_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
logic/capi_job_pkg.sv
logic/job_cmd_if.sv
logic/reset_timer.sv
logic/parity_checker.sv
logic/error_capture.sv
logic/job_sequencer.sv
logic/job_control.sv
tb/job_control_properties.sv
tb/job_control_tb.sv

// File: Makefile
# Verilator build and run of the job control testbench

VERILATOR ?= verilator
TOP       ?= job_control_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
